// File: source/lcStatePkg.sv
package lcStatePkg;

  // ----------------------------------------
  // Word and index widths
  // ----------------------------------------
  localparam int LcStateWordW = 32;
  localparam int LcCntWordW = 32;
  localparam int DecLcStateNumRep = 2;
  localparam int DecLcStateW = 5;
  localparam int DecLcCntW = 5;

  // Legal life cycle states run from Raw up to Scrap
  localparam int NumLcStates = 21;

  typedef enum logic [DecLcStateW-1:0] {
    DecLcStRaw = 5'd0,
    DecLcStTestUnlocked0, DecLcStTestLocked0,
    DecLcStTestUnlocked1, DecLcStTestLocked1,
    DecLcStTestUnlocked2, DecLcStTestLocked2,
    DecLcStTestUnlocked3, DecLcStTestLocked3,
    DecLcStTestUnlocked4, DecLcStTestLocked4,
    DecLcStTestUnlocked5, DecLcStTestLocked5,
    DecLcStTestUnlocked6, DecLcStTestLocked6,
    DecLcStTestUnlocked7,
    DecLcStDev, DecLcStProd, DecLcStProdEnd, DecLcStRma,
    DecLcStScrap = 5'd20,
    DecLcStInvalid = 5'd31
  } decLcState_e;

  // Every copy of a decoded index comes from separate decode logic
  typedef logic [DecLcStateNumRep-1:0][DecLcStateW-1:0] extDecLcState_t;

  // ----------------------------------------
  // OTP word encodings
  // ----------------------------------------
  // The upper bits hold a fixed marker and the lower bits a thermometer code,
  // so a forward move in OTP only ever sets bits
  localparam logic [10:0] LcStateMarker = 11'h5a6;
  localparam int LcStateThermW = LcStateWordW - 11;
  localparam logic [6:0] LcCntMarker = 7'h4b;
  localparam int LcCntThermW = LcCntWordW - 7;
  localparam logic [DecLcCntW-1:0] LcCntMax = 5'd24;

  // Returns a word with the lowest n bits set
  function automatic logic [31:0] thermOnes(int unsigned n);
    logic [31:0] t;
    for (int k = 0; k < 32; k++) begin
      t[k] = (k < n);
    end
    return t;
  endfunction

  // True when the set bits form one contiguous run starting at bit 0
  function automatic logic isThermo(logic [31:0] bits);
    return (bits & (bits + 32'd1)) == 32'd0;
  endfunction

  function automatic logic [LcStateWordW-1:0] encLcState(logic [DecLcStateW-1:0] idx);
    logic [31:0] t;
    t = thermOnes(idx);
    return {LcStateMarker, t[LcStateThermW-1:0]};
  endfunction

  function automatic logic [LcCntWordW-1:0] encLcCnt(logic [DecLcCntW-1:0] cnt);
    logic [31:0] t;
    t = thermOnes(cnt);
    return {LcCntMarker, t[LcCntThermW-1:0]};
  endfunction

  // ----------------------------------------
  // Transition rules
  // ----------------------------------------
  // Indexed as [current][target]
  typedef logic [NumLcStates-1:0][NumLcStates-1:0] transMatrix_t;

  // Moves only go forward and ProdEnd is terminal, but Scrap is reachable
  // from anywhere
  function automatic transMatrix_t genTransValid();
    transMatrix_t m;
    for (int src = 0; src < NumLcStates; src++) begin
      for (int dst = 0; dst < NumLcStates; dst++) begin
        m[src][dst] = ((dst > src) && (src != DecLcStProdEnd)) || (dst == DecLcStScrap);
      end
    end
    return m;
  endfunction

  localparam transMatrix_t TransValidMatrix = genTransValid();

endpackage

// File: source/lcCtrlPkg.sv
package lcCtrlPkg;

  // Phases of the main life cycle FSM, which lives outside this datapath
  typedef enum logic [2:0] {
    IdleSt,
    CntIncrSt,
    CntProgSt,
    TransCheckSt,
    TokenHashSt,
    TransProgSt
  } lcPhase_e;

  // Volatile RAW unlock is meant for test chips only
  localparam logic VolatileRawUnlockEn = 1'b1;

  // ----------------------------------------
  // Phase groupings, one bit per phase
  // ----------------------------------------
  // The counter increment stays asserted through the state programming pass,
  // since OTP programming is incremental
  localparam logic [7:0] CntPhases = (8'd1 << CntIncrSt) | (8'd1 << CntProgSt) |
                                     (8'd1 << TransCheckSt) | (8'd1 << TransProgSt);

  localparam logic [7:0] CheckPhases = (8'd1 << TransCheckSt) | (8'd1 << TokenHashSt) |
                                       (8'd1 << TransProgSt);

  // Phases in which an OTP write is requested
  localparam logic [7:0] ProgPhases = (8'd1 << CntProgSt) | (8'd1 << TransProgSt);

endpackage

// File: source/lcStateDecode.sv
module lcStateDecode
  import lcStatePkg::*;
  import lcCtrlPkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    valid_i,
  input  lcPhase_e                phase_i,
  input  logic [LcStateWordW-1:0] lcStateWord_i,
  input  logic [LcCntWordW-1:0]   lcCntWord_i,
  input  extDecLcState_t          transTarget_i,
  input  logic                    volatileRawUnlock_i,
  input  logic                    transCmd_i,
  output logic                    valid_o,
  output lcPhase_e                phase_o,
  output extDecLcState_t          decLcState_o,
  output logic [LcStateWordW-1:0] lcStateWord_o,
  output logic [DecLcCntW-1:0]    decLcCnt_o,
  output logic                    cntDecodeError_o,
  output extDecLcState_t          transTarget_o,
  output logic                    volatileRawUnlock_o,
  output logic                    transCmd_o
);

  logic [LcStateThermW-1:0] stateTherm;
  logic [LcCntThermW-1:0]   cntTherm;
  logic                     stateOk;
  logic                     cntOk;
  extDecLcState_t           decState;
  logic [DecLcCntW-1:0]     decCnt;

  assign stateTherm = lcStateWord_i[LcStateThermW-1:0];
  assign cntTherm = lcCntWord_i[LcCntThermW-1:0];

  // The top payload bit is never set in a legal word
  assign stateOk = (lcStateWord_i[LcStateWordW-1 -: 11] == LcStateMarker) &&
                   isThermo(32'(stateTherm)) && !stateTherm[LcStateThermW-1];
  assign cntOk = (lcCntWord_i[LcCntWordW-1 -: 7] == LcCntMarker) &&
                 isThermo(32'(cntTherm)) && !cntTherm[LcCntThermW-1];

  // Copy 0 counts the ones of a checked word and copy 1 matches every legal
  // encoding on its own, so one glitched path cannot produce a valid state
  always_comb begin
    decState[0] = DecLcStInvalid;
    decState[1] = DecLcStInvalid;
    if (stateOk) begin
      decState[0] = DecLcStateW'($countones(stateTherm));
    end
    for (int k = 0; k < NumLcStates; k++) begin
      if (lcStateWord_i == encLcState(DecLcStateW'(k))) begin
        decState[1] = DecLcStateW'(k);
      end
    end
  end

  // A corrupted counter saturates so that no further increment is possible
  assign decCnt = cntOk ? DecLcCntW'($countones(cntTherm)) : LcCntMax;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o             <= 1'b0;
      phase_o             <= IdleSt;
      decLcState_o        <= '0;
      lcStateWord_o       <= '0;
      decLcCnt_o          <= '0;
      cntDecodeError_o    <= 1'b0;
      transTarget_o       <= '0;
      volatileRawUnlock_o <= 1'b0;
      transCmd_o          <= 1'b0;
    end else begin
      valid_o             <= valid_i;
      phase_o             <= phase_i;
      decLcState_o        <= decState;
      lcStateWord_o       <= lcStateWord_i;
      decLcCnt_o          <= decCnt;
      cntDecodeError_o    <= !cntOk;
      transTarget_o       <= transTarget_i;
      volatileRawUnlock_o <= volatileRawUnlock_i;
      transCmd_o          <= transCmd_i;
    end
  end

  // Both decode paths agree on every item that leaves this stage
  assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o |-> decLcState_o[0] == decLcState_o[1]);

endmodule

// File: source/lcStateTransition.sv
module lcStateTransition
  import lcStatePkg::*;
  import lcCtrlPkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    valid_i,
  input  lcPhase_e                phase_i,
  input  extDecLcState_t          decLcState_i,
  input  logic [LcStateWordW-1:0] lcStateWord_i,
  input  logic [DecLcCntW-1:0]    decLcCnt_i,
  input  logic                    cntDecodeError_i,
  input  extDecLcState_t          transTarget_i,
  input  logic                    volatileRawUnlock_i,
  input  logic                    transCmd_i,
  output logic                    valid_o,
  output lcPhase_e                phase_o,
  output logic [LcStateWordW-1:0] lcStateWord_o,
  output logic [LcStateWordW-1:0] nextLcStateWord_o,
  output logic [LcCntWordW-1:0]   lcCntWord_o,
  output logic [LcCntWordW-1:0]   nextLcCntWord_o,
  output logic                    transCntOflwError_o,
  output logic                    transInvalidError_o,
  output logic                    cntDecodeError_o
);

  logic [LcCntWordW-1:0]   curCnt;
  logic [LcCntWordW-1:0]   nextCnt;
  logic [LcStateWordW-1:0] nextState;
  logic                    oflwErr;
  logic                    invalidErr;
  logic                    rangeOk;
  logic                    matrixOk;

  // The counter word is rebuilt from its decoded index
  assign curCnt = encLcCnt(decLcCnt_i);

  // Every copy must be in range before it may index the rule table
  always_comb begin
    rangeOk = 1'b1;
    for (int r = 0; r < DecLcStateNumRep; r++) begin
      rangeOk &= (decLcState_i[r] <= DecLcStScrap) && (transTarget_i[r] <= DecLcStScrap);
    end
  end

  // Each copy does its own lookup, and both must allow the move
  assign matrixOk = rangeOk && (transTarget_i[0] == transTarget_i[1]) &&
                    TransValidMatrix[decLcState_i[0]][transTarget_i[0]] &&
                    TransValidMatrix[decLcState_i[1]][transTarget_i[1]];

  always_comb begin
    // Nothing changes unless a phase below asks for it
    nextState  = lcStateWord_i;
    nextCnt    = curCnt;
    oflwErr    = 1'b0;
    invalidErr = 1'b0;

    // ----------------------------------------
    // Volatile RAW unlock
    // ----------------------------------------
    // Only RAW to TEST_UNLOCKED0 may pass this way
    if (VolatileRawUnlockEn && volatileRawUnlock_i && transCmd_i && phase_i == IdleSt) begin
      if (decLcState_i != {DecLcStateNumRep{DecLcStRaw}} ||
          transTarget_i != {DecLcStateNumRep{DecLcStTestUnlocked0}}) begin
        invalidErr = 1'b1;
      end
    end

    // ----------------------------------------
    // Counter increment
    // ----------------------------------------
    if (CntPhases[phase_i]) begin
      if (decLcCnt_i >= LcCntMax) begin
        oflwErr = 1'b1;
      end else begin
        nextCnt = encLcCnt(decLcCnt_i + DecLcCntW'(1));
      end
      // Scrap is always allowed
      // The counter is maxed and the state forced to Scrap right away, so the
      // silenced overflow cannot be used to reach any other state
      if (transTarget_i == {DecLcStateNumRep{DecLcStScrap}}) begin
        nextCnt   = encLcCnt(LcCntMax);
        nextState = encLcState(DecLcStScrap);
        oflwErr   = 1'b0;
      end
    end

    // ----------------------------------------
    // Transition check
    // ----------------------------------------
    if (CheckPhases[phase_i]) begin
      if (matrixOk) begin
        nextState = encLcState(transTarget_i[0]);
      end else begin
        // Covers corrupted state words too, which decode out of range
        invalidErr = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o             <= 1'b0;
      phase_o             <= IdleSt;
      lcStateWord_o       <= '0;
      nextLcStateWord_o   <= '0;
      lcCntWord_o         <= '0;
      nextLcCntWord_o     <= '0;
      transCntOflwError_o <= 1'b0;
      transInvalidError_o <= 1'b0;
      cntDecodeError_o    <= 1'b0;
    end else begin
      valid_o             <= valid_i;
      phase_o             <= phase_i;
      lcStateWord_o       <= lcStateWord_i;
      nextLcStateWord_o   <= nextState;
      lcCntWord_o         <= curCnt;
      nextLcCntWord_o     <= nextCnt;
      transCntOflwError_o <= oflwErr;
      transInvalidError_o <= invalidErr;
      cntDecodeError_o    <= cntDecodeError_i;
    end
  end

  // A Scrap request is never reported as a counter overflow
  assert property (@(posedge clk_i) disable iff (reset_i)
    valid_i && transTarget_i == {DecLcStateNumRep{DecLcStScrap}} |=> !transCntOflwError_o);

endmodule

// File: source/lcOtpProgWord.sv
module lcOtpProgWord
  import lcStatePkg::*;
  import lcCtrlPkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    valid_i,
  input  lcPhase_e                phase_i,
  input  logic [LcStateWordW-1:0] lcStateWord_i,
  input  logic [LcStateWordW-1:0] nextLcStateWord_i,
  input  logic [LcCntWordW-1:0]   lcCntWord_i,
  input  logic [LcCntWordW-1:0]   nextLcCntWord_i,
  input  logic                    transCntOflwError_i,
  input  logic                    transInvalidError_i,
  input  logic                    cntDecodeError_i,
  output logic                    valid_o,
  output logic [LcStateWordW-1:0] nextLcStateWord_o,
  output logic [LcCntWordW-1:0]   nextLcCntWord_o,
  output logic [LcStateWordW-1:0] progWord_o,
  output logic [LcStateWordW-1:0] progMask_o,
  output logic                    progReq_o,
  output logic                    transCntOflwError_o,
  output logic                    transInvalidError_o,
  output logic                    cntDecodeError_o
);

  logic [LcStateWordW-1:0] curWord;
  logic [LcStateWordW-1:0] newWord;
  logic [LcStateWordW-1:0] mask;
  logic                    req;

  // The counter pass and the state pass each write their own OTP word
  always_comb begin
    curWord = '0;
    newWord = '0;
    if (phase_i == CntProgSt) begin
      curWord = lcCntWord_i;
      newWord = nextLcCntWord_i;
    end else if (phase_i == TransProgSt) begin
      curWord = lcStateWord_i;
      newWord = nextLcStateWord_i;
    end
  end

  // OTP bits only burn from 0 to 1
  assign mask = newWord & ~curWord;

  assign req = valid_i && ProgPhases[phase_i] && (|mask) &&
               !(transCntOflwError_i || transInvalidError_i || cntDecodeError_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o             <= 1'b0;
      nextLcStateWord_o   <= '0;
      nextLcCntWord_o     <= '0;
      progWord_o          <= '0;
      progMask_o          <= '0;
      progReq_o           <= 1'b0;
      transCntOflwError_o <= 1'b0;
      transInvalidError_o <= 1'b0;
      cntDecodeError_o    <= 1'b0;
    end else begin
      valid_o             <= valid_i;
      nextLcStateWord_o   <= nextLcStateWord_i;
      nextLcCntWord_o     <= nextLcCntWord_i;
      progWord_o          <= newWord;
      progMask_o          <= mask;
      progReq_o           <= req;
      transCntOflwError_o <= transCntOflwError_i;
      transInvalidError_o <= transInvalidError_i;
      cntDecodeError_o    <= cntDecodeError_i;
    end
  end

  // A requested write keeps every bit that is already burnt
  assert property (@(posedge clk_i) disable iff (reset_i)
    progReq_o |-> (progWord_o & $past(curWord)) == $past(curWord));

endmodule

// File: source/lcTransitionPipe.sv
module lcTransitionPipe
  import lcStatePkg::*;
  import lcCtrlPkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    valid_i,
  input  lcPhase_e                phase_i,
  input  logic [LcStateWordW-1:0] lcStateWord_i,
  input  logic [LcCntWordW-1:0]   lcCntWord_i,
  input  extDecLcState_t          transTarget_i,
  input  logic                    volatileRawUnlock_i,
  input  logic                    transCmd_i,
  output logic                    valid_o,
  output logic [LcStateWordW-1:0] nextLcStateWord_o,
  output logic [LcCntWordW-1:0]   nextLcCntWord_o,
  output logic [LcStateWordW-1:0] progWord_o,
  output logic [LcStateWordW-1:0] progMask_o,
  output logic                    progReq_o,
  output logic                    transCntOflwError_o,
  output logic                    transInvalidError_o,
  output logic                    cntDecodeError_o
);

  // Decode stage to transition stage
  logic                    d1Valid;
  lcPhase_e                d1Phase;
  extDecLcState_t          d1DecLcState;
  logic [LcStateWordW-1:0] d1LcStateWord;
  logic [DecLcCntW-1:0]    d1DecLcCnt;
  logic                    d1CntDecodeError;
  extDecLcState_t          d1TransTarget;
  logic                    d1VolatileRawUnlock;
  logic                    d1TransCmd;

  // Transition stage to programming stage
  logic                    d2Valid;
  lcPhase_e                d2Phase;
  logic [LcStateWordW-1:0] d2LcStateWord;
  logic [LcStateWordW-1:0] d2NextLcStateWord;
  logic [LcCntWordW-1:0]   d2LcCntWord;
  logic [LcCntWordW-1:0]   d2NextLcCntWord;
  logic                    d2TransCntOflwError;
  logic                    d2TransInvalidError;
  logic                    d2CntDecodeError;

  lcStateDecode i_lcStateDecode (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .valid_i             (valid_i),
    .phase_i             (phase_i),
    .lcStateWord_i       (lcStateWord_i),
    .lcCntWord_i         (lcCntWord_i),
    .transTarget_i       (transTarget_i),
    .volatileRawUnlock_i (volatileRawUnlock_i),
    .transCmd_i          (transCmd_i),
    .valid_o             (d1Valid),
    .phase_o             (d1Phase),
    .decLcState_o        (d1DecLcState),
    .lcStateWord_o       (d1LcStateWord),
    .decLcCnt_o          (d1DecLcCnt),
    .cntDecodeError_o    (d1CntDecodeError),
    .transTarget_o       (d1TransTarget),
    .volatileRawUnlock_o (d1VolatileRawUnlock),
    .transCmd_o          (d1TransCmd)
  );

  lcStateTransition i_lcStateTransition (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .valid_i             (d1Valid),
    .phase_i             (d1Phase),
    .decLcState_i        (d1DecLcState),
    .lcStateWord_i       (d1LcStateWord),
    .decLcCnt_i          (d1DecLcCnt),
    .cntDecodeError_i    (d1CntDecodeError),
    .transTarget_i       (d1TransTarget),
    .volatileRawUnlock_i (d1VolatileRawUnlock),
    .transCmd_i          (d1TransCmd),
    .valid_o             (d2Valid),
    .phase_o             (d2Phase),
    .lcStateWord_o       (d2LcStateWord),
    .nextLcStateWord_o   (d2NextLcStateWord),
    .lcCntWord_o         (d2LcCntWord),
    .nextLcCntWord_o     (d2NextLcCntWord),
    .transCntOflwError_o (d2TransCntOflwError),
    .transInvalidError_o (d2TransInvalidError),
    .cntDecodeError_o    (d2CntDecodeError)
  );

  lcOtpProgWord i_lcOtpProgWord (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .valid_i             (d2Valid),
    .phase_i             (d2Phase),
    .lcStateWord_i       (d2LcStateWord),
    .nextLcStateWord_i   (d2NextLcStateWord),
    .lcCntWord_i         (d2LcCntWord),
    .nextLcCntWord_i     (d2NextLcCntWord),
    .transCntOflwError_i (d2TransCntOflwError),
    .transInvalidError_i (d2TransInvalidError),
    .cntDecodeError_i    (d2CntDecodeError),
    .valid_o             (valid_o),
    .nextLcStateWord_o   (nextLcStateWord_o),
    .nextLcCntWord_o     (nextLcCntWord_o),
    .progWord_o          (progWord_o),
    .progMask_o          (progMask_o),
    .progReq_o           (progReq_o),
    .transCntOflwError_o (transCntOflwError_o),
    .transInvalidError_o (transInvalidError_o),
    .cntDecodeError_o    (cntDecodeError_o)
  );

endmodule

// File: verification/lcTransitionChecker.sv
module lcTransitionChecker
  import lcStatePkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    inValid_i,
  input  logic                    outValid_i,
  input  logic [LcStateWordW-1:0] nextState_i,
  input  logic [LcCntWordW-1:0]   nextCnt_i,
  input  logic [LcStateWordW-1:0] progWord_i,
  input  logic [LcStateWordW-1:0] progMask_i,
  input  logic                    progReq_i,
  input  logic                    oflwError_i,
  input  logic                    invalidError_i,
  input  logic                    cntDecodeError_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Expected results in test order
  // The flags are packed as {oflw, invalid, cntDecode, req}
  string       nameQ[$];
  logic [31:0] expStateQ[$];
  logic [31:0] expCntQ[$];
  logic [31:0] expProgWordQ[$];
  logic [31:0] expMaskQ[$];
  logic [3:0]  expFlagsQ[$];

  // Cycle numbers at which valid_i was seen high
  int unsigned stampQ[$];
  int unsigned cycle = 0;
  int          passCount = 0;
  int          failCount = 0;
  int          errorCount = 0;
  int          doneCount = 0;

  task automatic pushExpected(string name, logic [31:0] expState, logic [31:0] expCnt,
                              logic [31:0] expProgWord, logic [3:0] expFlags,
                              logic [31:0] expMask);
    nameQ.push_back(name);
    expStateQ.push_back(expState);
    expCntQ.push_back(expCnt);
    expProgWordQ.push_back(expProgWord);
    expFlagsQ.push_back(expFlags);
    expMaskQ.push_back(expMask);
  endtask

  function automatic bit compareField(string testName, string field,
                                      logic [31:0] expVal, logic [31:0] actVal);
    if (actVal !== expVal) begin
      $display("mismatch %s %s expected %h actual %h", testName, field, expVal, actVal);
      return 1'b0;
    end
    return 1'b1;
  endfunction

  // ----------------------------------------
  // Per item checks
  // ----------------------------------------
  task automatic checkResetValues();
    if (outValid_i !== 1'b0 || progReq_i !== 1'b0 || oflwError_i !== 1'b0 ||
        invalidError_i !== 1'b0 || cntDecodeError_i !== 1'b0 ||
        nextState_i !== '0 || nextCnt_i !== '0 || progWord_i !== '0 ||
        progMask_i !== '0) begin
      $display("Outputs are not cleared while reset is held");
      errorCount++;
    end
  endtask

  // The oldest valid_i must be exactly 3 cycles old
  task automatic checkLatency();
    int unsigned stamp;
    if (stampQ.size() == 0) begin
      $display("valid_o rose with no matching valid_i");
      errorCount++;
    end else begin
      stamp = stampQ.pop_front();
      if (cycle - stamp != 3) begin
        $display("valid_o came %0d cycles after valid_i instead of 3", cycle - stamp);
        errorCount++;
      end
    end
  endtask

  task automatic checkOutput();
    string      testName;
    logic [3:0] flags;
    bit         ok;
    if (nameQ.size() == 0) begin
      $display("valid_o rose with no test waiting for a result");
      errorCount++;
    end else begin
      testName = nameQ.pop_front();
      flags = expFlagsQ.pop_front();
      ok = 1'b1;
      ok &= compareField(testName, "nextState", expStateQ.pop_front(), nextState_i);
      ok &= compareField(testName, "nextCnt", expCntQ.pop_front(), nextCnt_i);
      ok &= compareField(testName, "oflwError", 32'(flags[3]), 32'(oflwError_i));
      ok &= compareField(testName, "invalidError", 32'(flags[2]), 32'(invalidError_i));
      ok &= compareField(testName, "cntDecodeError", 32'(flags[1]), 32'(cntDecodeError_i));
      ok &= compareField(testName, "progReq", 32'(flags[0]), 32'(progReq_i));
      ok &= compareField(testName, "progWord", expProgWordQ.pop_front(), progWord_i);
      ok &= compareField(testName, "progMask", expMaskQ.pop_front(), progMask_i);
      if (ok) begin
        passCount++;
        $display("%s passed", testName);
      end else begin
        failCount++;
        $display("%s failed", testName);
      end
      doneCount++;
    end
  endtask

  // Sampling on the falling edge sees settled inputs and registered outputs
  always @(negedge clk_i) begin
    if (reset_i) begin
      checkResetValues();
    end else begin
      cycle++;
      if (inValid_i) begin
        stampQ.push_back(cycle);
      end
      if (outValid_i) begin
        checkLatency();
        checkOutput();
      end
      // An item older than the pipeline depth never came out
      if (stampQ.size() > 0 && cycle - stampQ[0] > 3) begin
        $display("valid_o did not rise 3 cycles after valid_i of cycle %0d", stampQ[0]);
        void'(stampQ.pop_front());
        errorCount++;
      end
    end
  end

endmodule

// File: verification/lcTransitionTb.sv
module lcTransitionTb
  import lcStatePkg::*;
  import lcCtrlPkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  logic                    clk;
  logic                    reset;
  logic                    validIn;
  lcPhase_e                phase;
  logic [LcStateWordW-1:0] lcStateWord;
  logic [LcCntWordW-1:0]   lcCntWord;
  extDecLcState_t          transTarget;
  logic                    volatileRawUnlock;
  logic                    transCmd;
  logic                    validOut;
  logic [LcStateWordW-1:0] nextLcStateWord;
  logic [LcCntWordW-1:0]   nextLcCntWord;
  logic [LcStateWordW-1:0] progWord;
  logic [LcStateWordW-1:0] progMask;
  logic                    progReq;
  logic                    transCntOflwError;
  logic                    transInvalidError;
  logic                    cntDecodeError;

  // Stimulus of every test in file order
  int          phaseQ[$];
  logic [31:0] stateQ[$];
  logic [31:0] cntQ[$];
  int          targetQ[$];
  logic        unlockQ[$];
  logic        cmdQ[$];
  int          numTests = 0;
  bit          loadOk = 1'b0;
  bit          loaded = 1'b0;

  // 40 ns clock period
  always #20 clk = ~clk;

  lcTransitionPipe i_lcTransitionPipe (
    .clk_i               (clk),
    .reset_i             (reset),
    .valid_i             (validIn),
    .phase_i             (phase),
    .lcStateWord_i       (lcStateWord),
    .lcCntWord_i         (lcCntWord),
    .transTarget_i       (transTarget),
    .volatileRawUnlock_i (volatileRawUnlock),
    .transCmd_i          (transCmd),
    .valid_o             (validOut),
    .nextLcStateWord_o   (nextLcStateWord),
    .nextLcCntWord_o     (nextLcCntWord),
    .progWord_o          (progWord),
    .progMask_o          (progMask),
    .progReq_o           (progReq),
    .transCntOflwError_o (transCntOflwError),
    .transInvalidError_o (transInvalidError),
    .cntDecodeError_o    (cntDecodeError)
  );

  lcTransitionChecker i_lcTransitionChecker (
    .clk_i            (clk),
    .reset_i          (reset),
    .inValid_i        (validIn),
    .outValid_i       (validOut),
    .nextState_i      (nextLcStateWord),
    .nextCnt_i        (nextLcCntWord),
    .progWord_i       (progWord),
    .progMask_i       (progMask),
    .progReq_i        (progReq),
    .oflwError_i      (transCntOflwError),
    .invalidError_i   (transInvalidError),
    .cntDecodeError_i (cntDecodeError)
  );

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  task automatic initInputs();
    clk = 1'b0;
    reset = 1'b1;
    validIn = 1'b0;
    phase = IdleSt;
    lcStateWord = '0;
    lcCntWord = '0;
    transTarget = '0;
    volatileRawUnlock = 1'b0;
    transCmd = 1'b0;
  endtask

  // The next counter word is written in CntProgSt and the next state word in
  // TransProgSt
  // No word is written in any other phase
  function automatic logic [31:0] expectedProgWord(int phaseVal, logic [31:0] expState,
                                                   logic [31:0] expCnt);
    if (phaseVal == int'(CntProgSt)) begin
      return expCnt;
    end else if (phaseVal == int'(TransProgSt)) begin
      return expState;
    end
    return 32'd0;
  endfunction

  // Stimulus goes to local queues and expected results straight to the checker
  task automatic loadTests();
    int          fd;
    int          fields;
    bit          badLine;
    string       line;
    string       name;
    int          phaseVal;
    int          targetVal;
    int          unlockVal;
    int          cmdVal;
    int          oflwVal;
    int          invalidVal;
    int          cntErrVal;
    int          reqVal;
    logic [31:0] stateVal;
    logic [31:0] cntVal;
    logic [31:0] expState;
    logic [31:0] expCnt;
    logic [31:0] expMask;
    badLine = 1'b0;
    fd = $fopen("verification/lcTransitionTests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test file");
    end else begin
      while ($fgets(line, fd) != 0) begin
        // Comment lines and blank lines hold no test
        if (line.len() > 1 && line.substr(0, 0) != "#") begin
          fields = $sscanf(line, "%s %d %h %h %d %d %d %h %h %d %d %d %d %h", name,
                           phaseVal, stateVal, cntVal, targetVal, unlockVal, cmdVal,
                           expState, expCnt, oflwVal, invalidVal, cntErrVal, reqVal,
                           expMask);
          if (fields != 14) begin
            $display("Malformed line in the test file: %s", line);
            badLine = 1'b1;
          end else begin
            phaseQ.push_back(phaseVal);
            stateQ.push_back(stateVal);
            cntQ.push_back(cntVal);
            targetQ.push_back(targetVal);
            unlockQ.push_back(unlockVal[0]);
            cmdQ.push_back(cmdVal[0]);
            i_lcTransitionChecker.pushExpected(name, expState, expCnt,
              expectedProgWord(phaseVal, expState, expCnt),
              {oflwVal[0], invalidVal[0], cntErrVal[0], reqVal[0]}, expMask);
            numTests++;
          end
        end
      end
      $fclose(fd);
      loadOk = !badLine && (numTests > 0);
    end
  endtask

  // Reset spans 3 rising edges and inputs move 2 ns after an edge
  task automatic applyReset();
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
  endtask

  // One test per cycle with no gaps, which also exercises full throughput
  task automatic driveTests();
    for (int i = 0; i < numTests; i++) begin
      @(posedge clk);
      #2;
      validIn = 1'b1;
      phase = lcPhase_e'(phaseQ[i]);
      lcStateWord = stateQ[i];
      lcCntWord = cntQ[i];
      // Both copies of the target carry the same index
      transTarget = {DecLcStateNumRep{DecLcStateW'(targetQ[i])}};
      volatileRawUnlock = unlockQ[i];
      transCmd = cmdQ[i];
    end
    @(posedge clk);
    #2;
    validIn = 1'b0;
  endtask

  initial begin
    initInputs();
    loadTests();
    loaded = 1'b1;
    if (loadOk) begin
      applyReset();
      driveTests();
      wait (i_lcTransitionChecker.doneCount == numTests);
      // A few more cycles let the checker catch any stray valid_o
      repeat (4) @(negedge clk);
    end
    $display("Tests %0d, passed %0d, failed %0d, other errors %0d", numTests,
             i_lcTransitionChecker.passCount, i_lcTransitionChecker.failCount,
             i_lcTransitionChecker.errorCount);
    if (loadOk && i_lcTransitionChecker.failCount == 0 &&
        i_lcTransitionChecker.errorCount == 0 &&
        i_lcTransitionChecker.passCount == numTests) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Every test needs one cycle, plus 20 cycles for reset and pipeline drain
  initial begin
    wait (loaded);
    #((numTests + 20) * 40);
    $display("Timeout, the DUT outputs stopped arriving");
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: verification/lcTransitionTests.txt
# name phase stateWord cntWord target unlock cmd expState expCnt oflw invalid cntErr req mask
# phase 0 Idle 1 CntIncr 2 CntProg 3 TransCheck 4 TokenHash 5 TransProg, words and mask in hex
cntIncrFromZero 1 b4c00000 96000000 0 0 0 b4c00000 96000001 0 0 0 0 00000000
cntIncrTo24 1 b4c00001 967fffff 2 0 0 b4c00001 96ffffff 0 0 0 0 00000000
cntIncrOverflow 1 b4c00001 96ffffff 2 0 0 b4c00001 96ffffff 1 0 0 0 00000000
cntProgOneBit 2 b4c0001f 9600001f 7 0 0 b4c0001f 9600003f 0 0 0 1 00000020
cntProgOverflow 2 b4c0001f 96ffffff 7 0 0 b4c0001f 96ffffff 1 0 0 0 00000000
transCheckFwd 3 b4c00001 96000003 5 0 0 b4c0001f 96000007 0 0 0 0 00000000
transProgDevToProd 5 b4c0ffff 96000007 17 0 0 b4c1ffff 9600000f 0 0 0 1 00010000
transCheckBackward 3 b4c1ffff 96000007 16 0 0 b4c1ffff 9600000f 0 1 0 0 00000000
transProgToRaw 5 b4c00001 96000001 0 0 0 b4c00001 96000003 0 1 0 0 00000000
transCheckSame 3 b4c0ffff 96000000 16 0 0 b4c0ffff 96000001 0 1 0 0 00000000
prodEndToRma 3 b4c3ffff 9600000f 19 0 0 b4c3ffff 9600001f 0 1 0 0 00000000
prodEndToScrap 5 b4c3ffff 9600000f 20 0 0 b4cfffff 96ffffff 0 0 0 1 000c0000
scrapFullCntProg 5 b4c0ffff 96ffffff 20 0 0 b4cfffff 96ffffff 0 0 0 1 000f0000
scrapFullCntCnt 2 b4c7ffff 96ffffff 20 0 0 b4cfffff 96ffffff 0 0 0 0 00000000
scrapFullCntIncr 1 b4c00001 96ffffff 20 0 0 b4cfffff 96ffffff 0 0 0 0 00000000
badStateMarker 3 b4800001 96000001 5 0 0 b4800001 96000003 0 1 0 0 00000000
stateNotThermo 5 b4c00005 96000001 5 0 0 b4c00005 96000003 0 1 0 0 00000000
badCntNotThermo 2 b4c00001 96000005 3 0 0 b4c00001 96ffffff 1 0 1 0 00000000
badCntMarker 5 b4c00001 16000003 3 0 0 b4c00007 96ffffff 1 0 1 0 00000006
volUnlockRawToTu0 0 b4c00000 96000000 1 1 1 b4c00000 96000000 0 0 0 0 00000000
volUnlockBadTarget 0 b4c00000 96000000 2 1 1 b4c00000 96000000 0 1 0 0 00000000
volUnlockBadSource 0 b4c00001 96000000 1 1 1 b4c00001 96000000 0 1 0 0 00000000
idleNoCmd 0 b4c00001 96000000 2 1 0 b4c00001 96000000 0 0 0 0 00000000
tokenHashFwd 4 b4c00003 96000003 3 0 0 b4c00007 96000003 0 0 0 0 00000000

// File: flist.f
source/lcStatePkg.sv
source/lcCtrlPkg.sv
source/lcStateDecode.sv
source/lcStateTransition.sv
source/lcOtpProgWord.sv
source/lcTransitionPipe.sv
verification/lcTransitionChecker.sv
verification/lcTransitionTb.sv

// File: run.sh
#!/bin/sh
# Build and run from the project root, the test file path is relative to it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module lcTransitionTb \
  -f flist.f -o lcTransitionSim || exit 1
simOut=$(./obj_dir/lcTransitionSim)
printf '%s\n' "$simOut"
printf '%s\n' "$simOut" | grep -qx 'Test OK' && exit 0 || exit 1
